// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_vga_display
FILELIST = sources.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(TOOL) and run $(TOP)"
	@echo "  clean  remove the build directory"

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	./$(BIN) | awk '{ print } /Everything OK/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// File: fb_pkg.sv
package fb_pkg;

  localparam int FB_ADDR_W     = 14;
  localparam int FB_WORD_W     = 16;
  localparam int ROW_WORDS     = 160;   // words per buffer row in quad mode
  localparam int LINES_PER_ROW = 8;     // scanlines sharing one row
  localparam int FB_DEPTH      = 9600;  // 60 rows of 160 words
  localparam int QUEUE_DEPTH   = 4;     // serializer queue, also credit count

  localparam int WORD_CNT_W = $clog2(ROW_WORDS + 1);    // up to 160
  localparam int CREDIT_W   = $clog2(QUEUE_DEPTH + 1);  // 0..4
  localparam int QPTR_W     = $clog2(QUEUE_DEPTH);      // queue index

  typedef enum logic {
    MODE_QUAD = 1'b0,  // four 4-bit indices per word
    MODE_MONO = 1'b1   // eight 1-bit pixels per word
  } display_mode_t;

  // mono cell, bits[7] is the leftmost pixel
  typedef struct packed {
    logic [3:0] fg;    // index for set bits
    logic [3:0] bg;    // index for clear bits
    logic [7:0] bits;
  } mono_cell_t;

  // quad pixel, idx[3] is the leftmost pixel
  typedef struct packed {
    logic [3:0][3:0] idx;
  } quad_pix_t;

  typedef union packed {
    mono_cell_t mono;
    quad_pix_t  quad;
  } fb_word_t;

endpackage

// File: frame_buffer.sv
module frame_buffer (
  input  logic                          sys_clk_i,   // host write clock
  input  logic                          wr_en_i,
  input  logic [fb_pkg::FB_ADDR_W-1:0]  wr_addr_i,
  input  logic [fb_pkg::FB_WORD_W-1:0]  wr_data_i,
  input  logic                          pxl_clk_i,   // display read clock
  input  logic                          rd_en_i,
  input  logic [fb_pkg::FB_ADDR_W-1:0]  rd_addr_i,
  output logic [fb_pkg::FB_WORD_W-1:0]  rd_data_o,   // one pixel clock after rd_en_i
  output logic                          rd_valid_o   // rd_en_i delayed
);
  import fb_pkg::*;

  logic [FB_WORD_W-1:0] mem_r [FB_DEPTH];  // block ram

  // host write port
  always_ff @(posedge sys_clk_i) begin
    if (wr_en_i) begin
      mem_r[wr_addr_i] <= wr_data_i;
    end
  end

  // registered read port
  always_ff @(posedge pxl_clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem_r[rd_addr_i];
    end
  end

  // follows rd_en_i, idle while fetch is held in reset
  always_ff @(posedge pxl_clk_i) begin
    rd_valid_o <= rd_en_i;
  end

  a_wr_addr_range: assert property (
    @(posedge sys_clk_i) wr_en_i |-> wr_addr_i < FB_ADDR_W'(FB_DEPTH)
  );

endmodule

// File: pixel_clk_gen.sv
module pixel_clk_gen (
  input  logic sys_clk_i,      // system clock
  input  logic reset_async_i,  // system reset
  output logic pxl_clk_o,      // sys_clk_i / 4
  output logic pxl_reset_o,    // pixel domain reset
  output logic ready_async_o   // pixel clock usable
);

  logic [1:0] div_cnt_r;   // divide by four
  logic [1:0] hold_cnt_r;  // pixel periods seen with reset held

  assign pxl_clk_o     = div_cnt_r[1];   // low while held in reset
  assign ready_async_o = ~pxl_reset_o;

  always_ff @(posedge sys_clk_i) begin
    if (reset_async_i) begin
      div_cnt_r   <= 2'b00;
      hold_cnt_r  <= 2'd0;
      pxl_reset_o <= 1'b1;
    end else begin
      div_cnt_r <= div_cnt_r + 2'd1;
      // step only on falling pixel edges so release never races a rising one
      if (pxl_reset_o && div_cnt_r == 2'b11) begin
        if (hold_cnt_r == 2'd3) begin
          pxl_reset_o <= 1'b0;  // after the 4th rising pixel edge
        end else begin
          hold_cnt_r <= hold_cnt_r + 2'd1;
        end
      end
    end
  end

  // divider held low during system reset
  a_no_rise_in_reset: assert property (
    @(posedge sys_clk_i) reset_async_i |=> !pxl_clk_o
  );

endmodule

// File: scanout_serializer.sv
module scanout_serializer (
  input  logic                          pxl_clk_i,
  input  logic                          pxl_reset_i,
  input  logic                          push_valid_i,   // word from frame buffer
  input  fb_pkg::fb_word_t              push_word_i,
  input  logic                          active_i,       // pixel in visible area
  input  fb_pkg::display_mode_t         frame_mode_i,
  output logic                          credit_return_o,
  output logic [vga_pkg::RGB_W-1:0]     rgb_o
);
  import vga_pkg::*;
  import fb_pkg::*;

  fb_word_t            queue_mem [QUEUE_DEPTH];  // word queue storage
  logic [QPTR_W-1:0]   wr_ptr_r;
  logic [QPTR_W-1:0]   rd_ptr_r;
  logic [CREDIT_W-1:0] q_count_r;
  fb_word_t            cur_word_r;   // word being shifted out
  fb_word_t            pix_word;
  logic                active_d_r;   // for rising edge of active_i
  logic [2:0]          phase_r;      // pixel within group
  logic [2:0]          cur_phase;
  logic [2:0]          phase_mask;
  logic                pop;
  logic [3:0]          pix_idx;      // palette index of this pixel

  always_comb begin
    phase_mask = (frame_mode_i == MODE_MONO) ? 3'd7 : 3'd3;  // 8 or 4 pixels
    cur_phase  = active_d_r ? phase_r : 3'd0;  // restart at line start
    pop        = active_i && (cur_phase == 3'd0);
    pix_word   = pop ? queue_mem[rd_ptr_r] : cur_word_r;  // head used on first pixel
    if (frame_mode_i == MODE_MONO) begin
      pix_idx = pix_word.mono.bits[3'd7 - cur_phase] ? pix_word.mono.fg
                                                    : pix_word.mono.bg;
    end else begin
      pix_idx = pix_word.quad.idx[2'd3 - cur_phase[1:0]];
    end
  end

  assign credit_return_o = pop;  // slot freed on every pop

  // queue storage and held word
  always_ff @(posedge pxl_clk_i) begin
    if (push_valid_i) begin
      queue_mem[wr_ptr_r] <= push_word_i;
    end
    if (pop) begin
      cur_word_r <= queue_mem[rd_ptr_r];
    end
  end

  always_ff @(posedge pxl_clk_i) begin
    if (pxl_reset_i) begin
      wr_ptr_r   <= '0;
      rd_ptr_r   <= '0;
      q_count_r  <= '0;
      active_d_r <= 1'b0;
      phase_r    <= 3'd0;
      rgb_o      <= '0;
    end else begin
      wr_ptr_r   <= wr_ptr_r + QPTR_W'(push_valid_i);  // wraps at depth 4
      rd_ptr_r   <= rd_ptr_r + QPTR_W'(pop);
      q_count_r  <= q_count_r + CREDIT_W'(push_valid_i) - CREDIT_W'(pop);
      active_d_r <= active_i;
      if (active_i) begin
        phase_r <= (cur_phase + 3'd1) & phase_mask;
      end
      rgb_o <= active_i ? PALETTE[pix_idx] : '0;  // blank outside visible area
    end
  end

  // fetch must have the word ready by group start
  a_no_pop_empty: assert property (
    @(posedge pxl_clk_i) disable iff (pxl_reset_i) pop |-> q_count_r != '0
  );

  // credit loop keeps the queue from overflowing
  a_no_push_full: assert property (
    @(posedge pxl_clk_i) disable iff (pxl_reset_i)
    push_valid_i |-> q_count_r != CREDIT_W'(QUEUE_DEPTH)
  );

endmodule

// File: sources.f
vga_pkg.sv
fb_pkg.sv
pixel_clk_gen.sv
vga_timing.sv
frame_buffer.sv
word_fetch.sv
scanout_serializer.sv
vga_display_top.sv
tb_vga_display.sv

// File: tb_vga_display.sv
module tb_vga_display;
  import fb_pkg::*;

  localparam int CLK_HALF     = 10;
  localparam int IN_DELAY     = 2;       // input skew after rising edge
  localparam int RESET_CYCLES = 5;
  localparam int H_PERIOD     = 800;     // pixel clocks per line
  localparam int H_LOW        = 96;
  localparam int V_PERIOD     = 420000;  // pixel clocks per frame
  localparam int V_LOW        = 1600;    // two lines
  localparam int X_OFFSET     = 144;     // hsync fall to pixel 0 of next line
  localparam int LINES        = 525;
  localparam int VS_LINE      = 490;     // first line with vsync low
  localparam int SWITCH_LINE  = 300;     // mode change inside frame 1
  localparam int QUIET_CLKS   = 600;     // well before the first hsync fall
  localparam int RUN_FRAMES   = 4;
  localparam longint WATCHDOG_TIME = longint'(RUN_FRAMES) * V_PERIOD * 4 * 2 * CLK_HALF;

  typedef struct packed {
    display_mode_t mode;   // decoding expected in this frame
    int            frame;
    int            x;      // 640 and up is front porch
    int            y;
    logic [11:0]   exp;
  } entry_t;

  logic                 sys_clk_i;
  logic                 reset_async_i;
  logic                 fb_wr_en_i;
  logic [FB_ADDR_W-1:0] fb_wr_addr_i;
  logic [FB_WORD_W-1:0] fb_wr_data_i;
  display_mode_t        mode_i;
  logic                 pxl_clk;
  logic                 vga_hsync;
  logic                 vga_vsync;
  logic [11:0]          vga_rgb;

  logic [15:0] mirror [FB_DEPTH];  // copy of every host write
  logic [31:0] rng_state;
  entry_t      tbl [$];
  int          idx;
  int          pos;         // pixel clocks since hsync fall
  int          hs_low;
  int          vs_low;
  int          vs_period;
  int          sync_line;   // line of the latest hsync fall
  int          row_y;       // line shown after that fall
  int          frame_no;
  logic        hs_prev;
  logic        vs_prev;
  logic        have_hs;
  logic        have_vs;
  logic        locked;      // line count known after first vsync

  vga_display_top dut_i (
    .sys_clk_i     (sys_clk_i),
    .reset_async_i (reset_async_i),
    .fb_wr_en_i    (fb_wr_en_i),
    .fb_wr_addr_i  (fb_wr_addr_i),
    .fb_wr_data_i  (fb_wr_data_i),
    .mode_i        (mode_i),
    .pxl_clk_o     (pxl_clk),
    .vga_hsync_o   (vga_hsync),
    .vga_vsync_o   (vga_vsync),
    .vga_rgb_o     (vga_rgb)
  );

  initial sys_clk_i = 1'b0;
  always #CLK_HALF sys_clk_i = ~sys_clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // red = i, green = 15 - i, blue = i xor 5
  function automatic logic [11:0] palette_rgb(input logic [3:0] i);
    return {i, 4'hF - i, i ^ 4'h5};
  endfunction

  function automatic logic [11:0] expected_rgb(input display_mode_t m, input int x, input int y);
    logic [15:0] w;
    logic [3:0]  ci;
    int          col;
    int          nib;
    if (x >= 640 || y >= 480) begin
      return 12'h000;  // blanking
    end
    col = (m == MODE_MONO) ? x / 8 : x / 4;
    w = mirror[FB_ADDR_W'((y / 8) * 160 + col)];  // 8 lines per row
    if (m == MODE_MONO) begin
      ci = w[4'(7 - x % 8)] ? w[15:12] : w[11:8];  // msb leftmost, set bit shows fg
    end else begin
      nib = 3 - x % 4;  // top nibble leftmost
      ci = w[4'(nib * 4) +: 4];
    end
    return palette_rgb(ci);
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic set_mode(input display_mode_t m);
    @(posedge sys_clk_i);
    #IN_DELAY;
    mode_i = m;
  endtask

  // pixel clock runs at a quarter of sys_clk_i
  task automatic check_pixel_clock();
    time t_rise;
    @(posedge pxl_clk);
    t_rise = $time;
    @(posedge pxl_clk);
    assert ($time - t_rise == 8 * CLK_HALF) else
      stop_run($sformatf("Fail pxl_clk_o period got %h expected %h",
                         $time - t_rise, 8 * CLK_HALF));
  endtask

  // outputs idle from the first pixel edge until the first line runs
  task automatic check_idle_outputs();
    @(negedge pxl_clk);
    repeat (QUIET_CLKS) begin
      assert (vga_hsync === 1'b1) else
        stop_run($sformatf("Fail vga_hsync_o got %h expected %h", vga_hsync, 1'b1));
      assert (vga_vsync === 1'b1) else
        stop_run($sformatf("Fail vga_vsync_o got %h expected %h", vga_vsync, 1'b1));
      assert (vga_rgb === 12'h000) else
        stop_run($sformatf("Fail vga_rgb_o got %h expected %h", vga_rgb, 12'h000));
      @(negedge pxl_clk);
    end
  endtask

  task automatic fill_frame_buffer();
    for (int a = 0; a < FB_DEPTH; a++) begin
      rng_state = xorshift32(rng_state);
      mirror[FB_ADDR_W'(a)] = rng_state[15:0];
      @(posedge sys_clk_i);
      #IN_DELAY;
      fb_wr_en_i   = 1'b1;
      fb_wr_addr_i = FB_ADDR_W'(a);
      fb_wr_data_i = rng_state[15:0];
    end
    @(posedge sys_clk_i);
    #IN_DELAY;
    fb_wr_en_i = 1'b0;
  endtask

  task automatic add_entry(input display_mode_t m, input int f, input int x, input int y);
    entry_t e;
    e.mode  = m;
    e.frame = f;
    e.x     = x;
    e.y     = y;
    e.exp   = expected_rgb(e.mode, e.x, e.y);
    tbl.push_back(e);
  endtask

  // time order, frame 1 quad with the switch at line 300, frame 2 mono
  task automatic build_table();
    add_entry(MODE_QUAD, 1, 0, 0);
    add_entry(MODE_QUAD, 1, 639, 0);
    add_entry(MODE_QUAD, 1, 100, 3);
    add_entry(MODE_QUAD, 1, 0, 7);
    add_entry(MODE_QUAD, 1, 255, 7);
    add_entry(MODE_QUAD, 1, 0, 8);
    add_entry(MODE_QUAD, 1, 517, 8);
    add_entry(MODE_QUAD, 1, 640, 8);
    add_entry(MODE_QUAD, 1, 655, 100);
    add_entry(MODE_QUAD, 1, 320, 240);
    add_entry(MODE_QUAD, 1, 13, 301);   // old decoding after the switch
    add_entry(MODE_QUAD, 1, 0, 479);
    add_entry(MODE_QUAD, 1, 639, 479);
    add_entry(MODE_QUAD, 1, 10, 480);
    add_entry(MODE_QUAD, 1, 300, 500);
    add_entry(MODE_QUAD, 1, 5, 524);
    add_entry(MODE_MONO, 2, 0, 0);
    add_entry(MODE_MONO, 2, 639, 0);
    add_entry(MODE_MONO, 2, 7, 7);
    add_entry(MODE_MONO, 2, 8, 8);
    add_entry(MODE_MONO, 2, 123, 64);
    add_entry(MODE_MONO, 2, 650, 64);
    add_entry(MODE_MONO, 2, 400, 300);
    add_entry(MODE_MONO, 2, 639, 479);
    add_entry(MODE_MONO, 2, 20, 490);
  endtask

  task automatic follow_display();
    while (idx < tbl.size()) begin
      @(negedge pxl_clk);  // stable half a pixel after the update
      pos++;
      vs_period++;
      if (hs_prev && !vga_hsync) begin
        if (have_hs) begin
          assert (pos == H_PERIOD) else
            stop_run($sformatf("Fail vga_hsync_o period got %h expected %h", pos, H_PERIOD));
        end
        have_hs = 1'b1;
        pos     = 0;
        hs_low  = 0;
        if (locked) begin
          sync_line = (sync_line + 1) % LINES;
          row_y     = (sync_line + 1) % LINES;  // pixels shown after this fall
          if (row_y == 0) begin
            frame_no++;
          end
        end
      end
      if (!hs_prev && vga_hsync && have_hs) begin
        assert (hs_low == H_LOW) else
          stop_run($sformatf("Fail vga_hsync_o low time got %h expected %h", hs_low, H_LOW));
      end
      if (vs_prev && !vga_vsync) begin
        if (have_vs) begin
          assert (vs_period == V_PERIOD) else
            stop_run($sformatf("Fail vga_vsync_o period got %h expected %h",
                               vs_period, V_PERIOD));
        end
        if (locked) begin
          assert (sync_line == VS_LINE - 1) else
            stop_run($sformatf("Fail vga_vsync_o line got %h expected %h",
                               sync_line + 1, VS_LINE));
        end
        have_vs   = 1'b1;
        vs_period = 0;
        vs_low    = 0;
        sync_line = VS_LINE - 1;  // latest hsync fall was on line 489
        locked    = 1'b1;
      end
      if (!vs_prev && vga_vsync && have_vs) begin
        assert (vs_low == V_LOW) else
          stop_run($sformatf("Fail vga_vsync_o low time got %h expected %h", vs_low, V_LOW));
      end
      if (!vga_hsync) begin
        hs_low++;
      end
      if (!vga_vsync) begin
        vs_low++;
      end
      if (locked && tbl[idx].frame == frame_no && tbl[idx].y == row_y &&
          tbl[idx].x + X_OFFSET == pos) begin
        assert (vga_rgb === tbl[idx].exp) else
          stop_run($sformatf("Fail vga_rgb_o got %h expected %h at x %0d y %0d frame %0d",
                             vga_rgb, tbl[idx].exp, tbl[idx].x, tbl[idx].y, frame_no));
        idx++;
      end
      hs_prev = vga_hsync;
      vs_prev = vga_vsync;
      if (locked && frame_no == 1 && row_y == SWITCH_LINE && mode_i == MODE_QUAD) begin
        set_mode(MODE_MONO);  // mid frame, due at frame 2 line 0
      end
    end
  endtask

  initial begin
    reset_async_i = 1'b1;
    fb_wr_en_i    = 1'b0;
    fb_wr_addr_i  = '0;
    fb_wr_data_i  = '0;
    mode_i        = MODE_QUAD;
    rng_state     = 32'd28;
    idx           = 0;
    pos           = 0;
    hs_low        = 0;
    vs_low        = 0;
    vs_period     = 0;
    sync_line     = 0;
    row_y         = -1;  // unknown until vsync seen
    frame_no      = 0;
    hs_prev       = 1'b1;
    vs_prev       = 1'b1;
    have_hs       = 1'b0;
    have_vs       = 1'b0;
    locked        = 1'b0;
    repeat (RESET_CYCLES) @(posedge sys_clk_i);
    #IN_DELAY;
    assert (pxl_clk === 1'b0) else
      stop_run($sformatf("Fail pxl_clk_o got %h expected %h", pxl_clk, 1'b0));
    reset_async_i = 1'b0;
    check_pixel_clock();
    check_idle_outputs();
    fill_frame_buffer();  // done within the first few lines of frame 0
    build_table();
    follow_display();
    $display("Everything OK");
    $finish;
  end

  // about three frames needed, four allowed
  initial begin
    #(WATCHDOG_TIME);
    stop_run("timeout, the display never reached every table entry");
  end

endmodule

// File: vga_display_top.sv
module vga_display_top (
  input  logic                          sys_clk_i,
  input  logic                          reset_async_i,
  input  logic                          fb_wr_en_i,     // host write strobe
  input  logic [fb_pkg::FB_ADDR_W-1:0]  fb_wr_addr_i,
  input  logic [fb_pkg::FB_WORD_W-1:0]  fb_wr_data_i,
  input  fb_pkg::display_mode_t         mode_i,         // applied at next frame
  output logic                          pxl_clk_o,      // also drives the pixel domain
  output logic                          vga_hsync_o,
  output logic                          vga_vsync_o,
  output logic [vga_pkg::RGB_W-1:0]     vga_rgb_o
);
  import vga_pkg::*;
  import fb_pkg::*;

  logic                  pxl_reset;
  logic [HCNT_W-1:0]     h_count;
  logic [VCNT_W-1:0]     v_count;
  logic                  active;
  display_mode_t         frame_mode;
  logic                  rd_en;
  logic [FB_ADDR_W-1:0]  rd_addr;
  fb_word_t              rd_data;     // raw word, decoded in the serializer
  logic                  push_valid;
  logic                  credit_return;

  pixel_clk_gen clk_gen_i (
    .sys_clk_i     (sys_clk_i),
    .reset_async_i (reset_async_i),
    .pxl_clk_o     (pxl_clk_o),
    .pxl_reset_o   (pxl_reset),
    .ready_async_o ()                // not needed with the divider
  );

  vga_timing timing_i (
    .pxl_clk_i    (pxl_clk_o),
    .pxl_reset_i  (pxl_reset),
    .mode_i       (mode_i),
    .h_count_o    (h_count),
    .v_count_o    (v_count),
    .active_o     (active),
    .frame_mode_o (frame_mode),
    .hsync_o      (vga_hsync_o),
    .vsync_o      (vga_vsync_o)
  );

  frame_buffer fb_i (
    .sys_clk_i  (sys_clk_i),
    .wr_en_i    (fb_wr_en_i),
    .wr_addr_i  (fb_wr_addr_i),
    .wr_data_i  (fb_wr_data_i),
    .pxl_clk_i  (pxl_clk_o),
    .rd_en_i    (rd_en),
    .rd_addr_i  (rd_addr),
    .rd_data_o  (rd_data),
    .rd_valid_o (push_valid)
  );

  word_fetch fetch_i (
    .pxl_clk_i       (pxl_clk_o),
    .pxl_reset_i     (pxl_reset),
    .h_count_i       (h_count),
    .v_count_i       (v_count),
    .frame_mode_i    (frame_mode),
    .credit_return_i (credit_return),
    .rd_en_o         (rd_en),
    .rd_addr_o       (rd_addr)
  );

  scanout_serializer ser_i (
    .pxl_clk_i       (pxl_clk_o),
    .pxl_reset_i     (pxl_reset),
    .push_valid_i    (push_valid),
    .push_word_i     (rd_data),
    .active_i        (active),
    .frame_mode_i    (frame_mode),
    .credit_return_o (credit_return),
    .rgb_o           (vga_rgb_o)
  );

endmodule

// File: vga_pkg.sv
package vga_pkg;

  // horizontal timing in pixel clocks
  localparam int H_ACTIVE = 640;
  localparam int H_FP     = 16;
  localparam int H_SYNC   = 96;
  localparam int H_TOTAL  = 800;

  // vertical timing in lines
  localparam int V_ACTIVE = 480;
  localparam int V_FP     = 10;
  localparam int V_SYNC   = 2;
  localparam int V_TOTAL  = 525;

  localparam int HCNT_W = $clog2(H_TOTAL);  // 10 bits
  localparam int VCNT_W = $clog2(V_TOTAL);  // 10 bits

  localparam int FETCH_START_H = 700;  // inside hsync, next line prefetch
  localparam int OUT_LATENCY   = 2;    // counters to pins
  localparam int RGB_W         = 12;   // 4 bits per gun

  // fixed palette {red, green, blue}
  // red = i, green = 15 - i, blue = i ^ 5
  localparam logic [RGB_W-1:0] PALETTE [16] = '{
    12'h0F5, 12'h1E4, 12'h2D7, 12'h3C6,
    12'h4B1, 12'h5A0, 12'h693, 12'h782,
    12'h87D, 12'h96C, 12'hA5F, 12'hB4E,
    12'hC39, 12'hD28, 12'hE1B, 12'hF0A
  };

endpackage

// File: vga_timing.sv
module vga_timing (
  input  logic                          pxl_clk_i,
  input  logic                          pxl_reset_i,
  input  fb_pkg::display_mode_t         mode_i,        // host side, quasi static
  output logic [vga_pkg::HCNT_W-1:0]    h_count_o,
  output logic [vga_pkg::VCNT_W-1:0]    v_count_o,
  output logic                          active_o,      // one clock behind counters
  output fb_pkg::display_mode_t         frame_mode_o,
  output logic                          hsync_o,       // active low
  output logic                          vsync_o        // active low
);
  import vga_pkg::*;
  import fb_pkg::*;

  logic h_last;
  logic v_last;
  logic active_now;
  logic hs_now;
  logic vs_now;
  logic [OUT_LATENCY-1:0] hs_pipe_r;  // sync delay to match rgb
  logic [OUT_LATENCY-1:0] vs_pipe_r;
  display_mode_t mode_meta_r;  // two flop sync of mode_i
  display_mode_t mode_sync_r;

  always_comb begin
    h_last     = (h_count_o == HCNT_W'(H_TOTAL - 1));
    v_last     = (v_count_o == VCNT_W'(V_TOTAL - 1));
    active_now = (h_count_o < HCNT_W'(H_ACTIVE)) && (v_count_o < VCNT_W'(V_ACTIVE));
    hs_now     = !((h_count_o >= HCNT_W'(H_ACTIVE + H_FP)) &&
                   (h_count_o <  HCNT_W'(H_ACTIVE + H_FP + H_SYNC)));
    vs_now     = !((v_count_o >= VCNT_W'(V_ACTIVE + V_FP)) &&
                   (v_count_o <  VCNT_W'(V_ACTIVE + V_FP + V_SYNC)));
  end

  always_ff @(posedge pxl_clk_i) begin
    mode_meta_r <= mode_i;
    mode_sync_r <= mode_meta_r;
  end

  always_ff @(posedge pxl_clk_i) begin
    if (pxl_reset_i) begin
      h_count_o    <= '0;
      v_count_o    <= VCNT_W'(V_TOTAL - 1);  // start on last blank line so line 0 is fetched
      active_o     <= 1'b0;
      frame_mode_o <= MODE_QUAD;
      hs_pipe_r    <= '1;
      vs_pipe_r    <= '1;
    end else begin
      h_count_o <= h_last ? '0 : h_count_o + 1'b1;
      if (h_last) begin
        v_count_o <= v_last ? '0 : v_count_o + 1'b1;
      end
      active_o  <= active_now;
      hs_pipe_r <= {hs_pipe_r[OUT_LATENCY-2:0], hs_now};
      vs_pipe_r <= {vs_pipe_r[OUT_LATENCY-2:0], vs_now};
      // frame boundary, taken just before the line 0 fetch starts
      if (v_last && h_count_o == HCNT_W'(FETCH_START_H - 1)) begin
        frame_mode_o <= mode_sync_r;
      end
    end
  end

  assign hsync_o = hs_pipe_r[OUT_LATENCY-1];
  assign vsync_o = vs_pipe_r[OUT_LATENCY-1];

  a_h_in_range: assert property (
    @(posedge pxl_clk_i) disable iff (pxl_reset_i) h_count_o < HCNT_W'(H_TOTAL)
  );

endmodule

// File: word_fetch.sv
module word_fetch (
  input  logic                          pxl_clk_i,
  input  logic                          pxl_reset_i,
  input  logic [vga_pkg::HCNT_W-1:0]    h_count_i,
  input  logic [vga_pkg::VCNT_W-1:0]    v_count_i,
  input  fb_pkg::display_mode_t         frame_mode_i,
  input  logic                          credit_return_i,  // one per serializer pop
  output logic                          rd_en_o,
  output logic [fb_pkg::FB_ADDR_W-1:0]  rd_addr_o
);
  import vga_pkg::*;
  import fb_pkg::*;

  logic [VCNT_W-1:0]     next_line;
  logic [FB_ADDR_W-1:0]  row_base;
  logic [WORD_CNT_W-1:0] line_words;
  logic                  fetch_start;
  logic [WORD_CNT_W-1:0] words_left_r;  // reads still to issue this line
  logic [FB_ADDR_W-1:0]  addr_r;
  logic [CREDIT_W-1:0]   credit_cnt_r;  // free queue slots

  always_comb begin
    next_line   = (v_count_i == VCNT_W'(V_TOTAL - 1)) ? '0 : v_count_i + 1'b1;
    row_base    = FB_ADDR_W'((next_line / LINES_PER_ROW) * ROW_WORDS);  // 8 lines per row
    line_words  = (frame_mode_i == MODE_MONO) ? WORD_CNT_W'(ROW_WORDS / 2)
                                              : WORD_CNT_W'(ROW_WORDS);
    fetch_start = (h_count_i == HCNT_W'(FETCH_START_H)) &&
                  (next_line < VCNT_W'(V_ACTIVE));
  end

  assign rd_en_o   = (words_left_r != '0) && (credit_cnt_r != '0);
  assign rd_addr_o = addr_r;

  always_ff @(posedge pxl_clk_i) begin
    if (pxl_reset_i) begin
      words_left_r <= '0;
      credit_cnt_r <= CREDIT_W'(QUEUE_DEPTH);
    end else begin
      if (fetch_start) begin
        words_left_r <= line_words;
      end else if (rd_en_o) begin
        words_left_r <= words_left_r - 1'b1;
      end
      // read takes a slot, pop gives one back
      credit_cnt_r <= credit_cnt_r - CREDIT_W'(rd_en_o) + CREDIT_W'(credit_return_i);
    end
  end

  // sequential addresses within the row
  always_ff @(posedge pxl_clk_i) begin
    if (fetch_start) begin
      addr_r <= row_base;
    end else if (rd_en_o) begin
      addr_r <= addr_r + 1'b1;
    end
  end

  a_credit_bound: assert property (
    @(posedge pxl_clk_i) disable iff (pxl_reset_i)
    credit_cnt_r <= CREDIT_W'(QUEUE_DEPTH)
  );

  // out of credits, no read until the serializer returns one
  a_no_read_dry: assert property (
    @(posedge pxl_clk_i) disable iff (pxl_reset_i)
    (credit_cnt_r == '0 && !credit_return_i) |=> !rd_en_o
  );

endmodule
